//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_l2_mem_sys
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb.f
verilog/l2_serdes_pkg.sv
verilog/l2_serdes.sv
verilog/burst_mem.sv
verilog/l2_mem_sys.sv
testbench/l2_serdes_assert.sv
testbench/tb_l2_mem_sys.sv

//--- testbench/l2_serdes_assert.sv
/*
 * Protocol checks on the line-to-beat converter.
 * Bound into every l2_serdes instance.
 */

`timescale 1ns/100ps

module l2_serdes_assert (
    input  logic                            i_clk,
    input  logic                            i_nrst,
    input  l2_serdes_pkg::serdes_state_t    i_state,
    input  logic                            i_mem_w_valid,
    input  logic                            i_mem_w_ready,
    input  logic                            i_mem_w_last,
    input  logic                            i_r_valid,
    input  logic                            i_b_valid,
    input  logic                            i_mem_b_valid,
    input  logic                            i_mem_ar_valid,
    input  logic                            i_mem_aw_valid
);
    import l2_serdes_pkg::*;

    // No further beat once the last one is taken
    a_w_last: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_mem_w_valid && i_mem_w_ready && i_mem_w_last) |=> !i_mem_w_valid)
        else $error("Write beat sent after the last beat of the burst");

    a_r_state: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_r_valid |=> (i_state == ST_IDLE))
        else $error("Converter did not return to idle after the read response");

    // Every bus write response reaches the cache side
    a_b_pass: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_mem_b_valid |-> i_b_valid)
        else $error("Bus write response was not forwarded");

    a_addr_take: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_mem_ar_valid || i_mem_aw_valid) |=> (i_state != ST_IDLE))
        else $error("Bus address was not taken in a single cycle");

endmodule

bind l2_serdes l2_serdes_assert chk0 (
    .i_clk(i_clk), .i_nrst(i_nrst), .i_state(state),
    .i_mem_w_valid(o_mem_w_valid), .i_mem_w_ready(i_mem_w_ready),
    .i_mem_w_last(o_mem_w_last),
    .i_r_valid(o_r_valid), .i_b_valid(o_b_valid), .i_mem_b_valid(i_mem_b_valid),
    .i_mem_ar_valid(o_mem_ar_valid), .i_mem_aw_valid(o_mem_aw_valid)
);

//--- testbench/tb_l2_mem_sys.sv
/*
 * Testbench for the line memory subsystem. Sends line reads and writes
 * through the converter, predicts each result with a reference memory
 * and checks every response strobe against it.
 */

`timescale 1ns/100ps

module tb_l2_mem_sys;
    import l2_serdes_pkg::*;

    localparam int TIMEOUT_CYC = 4000;  // Roughly three times the full run

    logic       i_clk, i_nrst, i_mem_stall;
    logic       i_ar_valid, i_aw_valid, o_ar_ready, o_aw_ready, o_r_valid, o_b_valid;
    addr_t      i_ar_addr, i_aw_addr;
    size_t      i_ar_size, i_aw_size;
    id_t        i_ar_id, i_aw_id, o_r_id, o_b_id;
    line_t      i_w_data, o_r_data;
    line_strb_t i_w_strb;
    resp_t      o_r_resp, o_b_resp;

    bus_t        ref_mem [MEM_WORDS];   // Expected memory contents
    logic [31:0] lfsr, stall_lfsr;
    logic        stall_en, rd_pending, wr_pending;
    line_t       exp_r_data;
    resp_t       exp_r_resp, exp_b_resp;
    id_t         exp_r_id, exp_b_id;
    int          errors, checks, cycles;

    l2_mem_sys dut0 (.*);

    always #10 i_clk = ~i_clk;

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic rand_line(output line_t l);
        logic [63:0] v;
        for (int k = 0; k < BEATS; k++) begin
            rand_bits(64, v);
            l[k*BUS_W +: BUS_W] = v;
        end
    endtask

    function automatic int beats_of(input size_t s);
        return (s <= 3'd3) ? 1 : ((s == 3'd4) ? 2 : BEATS);
    endfunction

    function automatic resp_t resp_of(input addr_t a);
        return a[11] ? RESP_SLVERR : RESP_OKAY;
    endfunction

    // Lanes outside the burst stay zero, as does the whole line out of range
    function automatic line_t ref_read(input addr_t a, input size_t s);
        line_t      l;
        logic [7:0] w;
        l = '0;
        for (int k = 0; k < beats_of(s); k++) begin
            w = a[10:3] + 8'(k);    // Word index wraps inside the array
            if (!a[11]) begin
                l[k*BUS_W +: BUS_W] = ref_mem[w];
            end
        end
        return l;
    endfunction

    task automatic ref_write(input addr_t a, input size_t s, input line_t d,
                             input line_strb_t st);
        logic [7:0] w;
        for (int k = 0; k < beats_of(s); k++) begin
            w = a[10:3] + 8'(k);
            for (int b = 0; b < BUS_B; b++) begin
                if (!a[11] && st[k*BUS_B + b]) begin
                    ref_mem[w][b*8 +: 8] = d[k*BUS_W + b*8 +: 8];
                end
            end
        end
    endtask

    task automatic expect_read(input addr_t a, input size_t s, input id_t id);
        exp_r_data = ref_read(a, s);
        exp_r_resp = resp_of(a);
        exp_r_id   = id;
        rd_pending = 1'b1;
    endtask

    task automatic expect_write(input addr_t a, input size_t s, input id_t id,
                                input line_t d, input line_strb_t st);
        exp_b_resp = resp_of(a);
        exp_b_id   = id;
        wr_pending = 1'b1;
        ref_write(a, s, d, st);
    endtask

    task automatic drive_read(input addr_t a, input size_t s, input id_t id);
        i_ar_valid <= 1'b1;
        i_ar_addr  <= a;
        i_ar_size  <= s;
        i_ar_id    <= id;
    endtask

    task automatic drive_write(input addr_t a, input size_t s, input id_t id,
                               input line_t d, input line_strb_t st);
        i_aw_valid <= 1'b1;
        i_aw_addr  <= a;
        i_aw_size  <= s;
        i_aw_id    <= id;
        i_w_data   <= d;
        i_w_strb   <= st;
    endtask

    task automatic read_line(input addr_t a, input size_t s, input id_t id);
        expect_read(a, s, id);
        @(posedge i_clk);
        drive_read(a, s, id);
        @(negedge i_clk);
        while (!o_ar_ready) @(negedge i_clk);
        @(posedge i_clk);
        i_ar_valid <= 1'b0;
        while (rd_pending) @(posedge i_clk);
    endtask

    task automatic write_line(input addr_t a, input size_t s, input id_t id,
                              input line_t d, input line_strb_t st);
        expect_write(a, s, id, d, st);
        @(posedge i_clk);
        drive_write(a, s, id, d, st);
        @(negedge i_clk);
        while (!o_aw_ready) @(negedge i_clk);
        @(posedge i_clk);
        i_aw_valid <= 1'b0;
        while (wr_pending) @(posedge i_clk);
    endtask

    // Response checker, outputs are settled at the falling edge
    always @(negedge i_clk) begin
        if (o_r_valid) begin
            checks++;
            if (!rd_pending) begin
                errors++;
                $display("Read response at %0t with no read outstanding", $time);
            end else begin
                if (o_r_data !== exp_r_data) begin
                    errors++;
                    $display("ERROR %0t o_r_data got %h expected %h",
                             $time, o_r_data, exp_r_data);
                end
                if (o_r_resp !== exp_r_resp) begin
                    errors++;
                    $display("ERROR %0t o_r_resp got %0d expected %0d",
                             $time, o_r_resp, exp_r_resp);
                end
                if (o_r_id !== exp_r_id) begin
                    errors++;
                    $display("ERROR %0t o_r_id got %0d expected %0d", $time, o_r_id, exp_r_id);
                end
            end
            rd_pending = 1'b0;
        end
        if (o_b_valid) begin
            checks++;
            if (!wr_pending) begin
                errors++;
                $display("Write response at %0t with no write outstanding", $time);
            end else begin
                if (o_b_resp !== exp_b_resp) begin
                    errors++;
                    $display("ERROR %0t o_b_resp got %0d expected %0d",
                             $time, o_b_resp, exp_b_resp);
                end
                if (o_b_id !== exp_b_id) begin
                    errors++;
                    $display("ERROR %0t o_b_id got %0d expected %0d", $time, o_b_id, exp_b_id);
                end
            end
            wr_pending = 1'b0;
        end
    end

    // Wait states from a separate LFSR stream
    always @(posedge i_clk) begin
        if (stall_en) begin
            i_mem_stall <= stall_lfsr[31];
            stall_lfsr = lfsr_next(stall_lfsr);
        end else begin
            i_mem_stall <= 1'b0;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a response never arrived", TIMEOUT_CYC);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [63:0] r;
        line_t       d;
        line_strb_t  st;
        addr_t       a;
        size_t       sz;
        id_t         id;
        i_clk       = 1'b0;
        i_nrst      = 1'b0;
        i_mem_stall = 1'b0;
        i_ar_valid  = 1'b0;
        i_ar_addr   = '0;
        i_ar_size   = '0;
        i_ar_id     = '0;
        i_aw_valid  = 1'b0;
        i_aw_addr   = '0;
        i_aw_size   = '0;
        i_aw_id     = '0;
        i_w_data    = '0;
        i_w_strb    = '0;
        lfsr        = 32'd87681;
        stall_lfsr  = 32'd87681;
        stall_en    = 1'b0;
        rd_pending  = 1'b0;
        wr_pending  = 1'b0;
        errors      = 0;
        checks      = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;                // Memory model clears on reset
        end

        repeat (16) @(posedge i_clk);
        i_nrst <= 1'b1;
        @(negedge i_clk);
        if (o_ar_ready !== 1'b1 || o_aw_ready !== 1'b1) begin
            errors++;
            $display("Request ready signals are not high after reset");
        end
        if (o_r_valid !== 1'b0 || o_b_valid !== 1'b0) begin
            errors++;
            $display("A response strobe is active right after reset");
        end

        // Full line write and read back
        rand_line(d);
        write_line(12'h140, 3'd5, 4'h3, d, '1);
        read_line(12'h140, 3'd5, 4'h3);

        // Partial strobes merge into the same line
        for (int i = 0; i < 8; i++) begin
            rand_line(d);
            rand_bits(32, r);
            write_line(12'h140, 3'd5, 4'(i), d, r[31:0]);
            read_line(12'h140, 3'd5, 4'(i + 8));
        end

        // Short bursts, then a full read to see what they touched
        for (int s = 2; s <= 4; s++) begin
            rand_line(d);
            write_line(12'h200, size_t'(s), 4'(s), d, '1);
            read_line(12'h200, size_t'(s), 4'(s));
            read_line(12'h200, 3'd5, 4'(s + 1));
        end

        // Upper 2 KB is out of range and aliases nothing
        rand_line(d);
        write_line(12'h940, 3'd5, 4'hA, d, '1);
        read_line(12'h940, 3'd5, 4'hB);
        read_line(12'h140, 3'd5, 4'hC);

        stall_en <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            rand_bits(20, r);
            a  = {r[11] & r[10], 3'b000, r[7:0]};   // 32 words, some out of range
            sz = r[14:12];
            id = r[19:16];
            if (r[15]) begin
                read_line(a, sz, id);
            end else begin
                rand_line(d);
                rand_bits(32, r);
                write_line(a, sz, id, d, r[31:0]);
            end
        end
        stall_en <= 1'b0;

        // Read and write presented in the same cycle
        for (int i = 0; i < 2; i++) begin
            rand_line(d);
            rand_bits(32, r);
            st = r[31:0];
            expect_read(12'h300, 3'd5, 4'h5);
            expect_write(12'h300, 3'd5, 4'h6, d, st);
            @(posedge i_clk);
            drive_read(12'h300, 3'd5, 4'h5);
            drive_write(12'h300, 3'd5, 4'h6, d, st);
            @(negedge i_clk);
            while (!o_ar_ready) @(negedge i_clk);
            if (o_aw_ready) begin
                errors++;
                $display("Write ready is high while a read is being accepted");
            end
            @(posedge i_clk);
            i_ar_valid <= 1'b0;
            @(negedge i_clk);
            while (!o_aw_ready) @(negedge i_clk);
            if (rd_pending) begin
                errors++;
                $display("Write was accepted before the read response");
            end
            @(posedge i_clk);
            i_aw_valid <= 1'b0;
            while (rd_pending || wr_pending) @(posedge i_clk);
        end

        repeat (4) @(posedge i_clk);        // Catch any stray strobe
        $display("Responses checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog/burst_mem.sv
/*
 * Behavioural 64-bit burst memory used as the bus-side target.
 * Fixed read latency, wait states while i_stall is high, and an
 * error response for any address in the upper 2 KB.
 */

`timescale 1ns/100ps

module burst_mem (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_stall,
    input  logic                        i_ar_valid,
    output logic                        o_ar_ready,
    input  l2_serdes_pkg::addr_t        i_ar_addr,
    input  l2_serdes_pkg::len_t         i_ar_len,
    input  l2_serdes_pkg::id_t          i_ar_id,
    input  logic                        i_aw_valid,
    output logic                        o_aw_ready,
    input  l2_serdes_pkg::addr_t        i_aw_addr,
    input  l2_serdes_pkg::len_t         i_aw_len,
    input  l2_serdes_pkg::id_t          i_aw_id,
    input  logic                        i_w_valid,
    output logic                        o_w_ready,
    input  l2_serdes_pkg::bus_t         i_w_data,
    input  l2_serdes_pkg::bus_strb_t    i_w_strb,
    input  logic                        i_w_last,
    output logic                        o_r_valid,
    output l2_serdes_pkg::bus_t         o_r_data,
    output l2_serdes_pkg::resp_t        o_r_resp,
    output l2_serdes_pkg::id_t          o_r_id,
    output logic                        o_r_last,
    output logic                        o_b_valid,
    output l2_serdes_pkg::resp_t        o_b_resp,
    output l2_serdes_pkg::id_t          o_b_id
);
    import l2_serdes_pkg::*;

    mem_state_t                     state;
    bus_t                           mem [MEM_WORDS];
    logic [$clog2(MEM_WORDS)-1:0]   word_q;     // Current word index
    len_t                           len_q;      // Beats left minus one
    id_t                            id_q;
    logic                           err_q;      // Burst is out of range
    logic [7:0]                     lat_q;

    assign o_ar_ready = (state == MS_IDLE);
    assign o_aw_ready = (state == MS_IDLE) & ~i_ar_valid;
    assign o_w_ready  = (state == MS_WRITE) & ~i_stall;

    assign o_r_valid = (state == MS_READ) & ~i_stall;
    assign o_r_data  = err_q ? '0 : mem[word_q];
    assign o_r_resp  = err_q ? RESP_SLVERR : RESP_OKAY;
    assign o_r_id    = id_q;
    assign o_r_last  = o_r_valid & (len_q == '0);

    assign o_b_valid = (state == MS_RESP);
    assign o_b_resp  = err_q ? RESP_SLVERR : RESP_OKAY;
    assign o_b_id    = id_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state  <= MS_IDLE;
            word_q <= '0;
            len_q  <= '0;
            id_q   <= '0;
            err_q  <= 1'b0;
            lat_q  <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                MS_IDLE: begin
                    if (i_ar_valid) begin
                        state  <= MS_RLAT;
                        word_q <= i_ar_addr[ADDR_W-2:3];
                        len_q  <= i_ar_len;
                        id_q   <= i_ar_id;
                        err_q  <= i_ar_addr[ADDR_W-1];
                        lat_q  <= 8'(MEM_LAT - 2);  // RLAT lasts MEM_LAT-1 cycles
                    end else if (i_aw_valid) begin
                        state  <= MS_WRITE;
                        word_q <= i_aw_addr[ADDR_W-2:3];
                        len_q  <= i_aw_len;
                        id_q   <= i_aw_id;
                        err_q  <= i_aw_addr[ADDR_W-1];
                    end
                end
                MS_RLAT: begin
                    if (lat_q == '0) begin
                        state <= MS_READ;
                    end else begin
                        lat_q <= lat_q - 8'd1;
                    end
                end
                MS_READ: begin
                    if (o_r_valid) begin
                        if (len_q == '0) begin
                            state <= MS_IDLE;
                        end else begin
                            word_q <= word_q + 1'b1;
                            len_q  <= len_q - 8'd1;
                        end
                    end
                end
                MS_WRITE: begin
                    if (i_w_valid && o_w_ready) begin
                        if (!err_q) begin
                            for (int b = 0; b < BUS_B; b++) begin
                                if (i_w_strb[b]) begin
                                    mem[word_q][b*8 +: 8] <= i_w_data[b*8 +: 8];
                                end
                            end
                        end
                        word_q <= word_q + 1'b1;
                        if (i_w_last) begin
                            state <= MS_RESP;
                        end
                    end
                end
                MS_RESP: state <= MS_IDLE;      // B is a one-cycle strobe
                default: state <= MS_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/l2_mem_sys.sv
/*
 * Top level of the line memory subsystem: the line-to-beat
 * converter in front of the burst memory model.
 * i_mem_stall inserts wait states on the bus side.
 */

`timescale 1ns/100ps

module l2_mem_sys (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_mem_stall,
    input  logic                        i_ar_valid,
    output logic                        o_ar_ready,
    input  l2_serdes_pkg::addr_t        i_ar_addr,
    input  l2_serdes_pkg::size_t        i_ar_size,
    input  l2_serdes_pkg::id_t          i_ar_id,
    input  logic                        i_aw_valid,
    output logic                        o_aw_ready,
    input  l2_serdes_pkg::addr_t        i_aw_addr,
    input  l2_serdes_pkg::size_t        i_aw_size,
    input  l2_serdes_pkg::id_t          i_aw_id,
    input  l2_serdes_pkg::line_t        i_w_data,
    input  l2_serdes_pkg::line_strb_t   i_w_strb,
    output logic                        o_r_valid,
    output l2_serdes_pkg::line_t        o_r_data,
    output l2_serdes_pkg::resp_t        o_r_resp,
    output l2_serdes_pkg::id_t          o_r_id,
    output logic                        o_b_valid,
    output l2_serdes_pkg::resp_t        o_b_resp,
    output l2_serdes_pkg::id_t          o_b_id
);
    import l2_serdes_pkg::*;

    // Bus between converter and memory
    logic       mem_ar_valid, mem_ar_ready;
    addr_t      mem_ar_addr;
    len_t       mem_ar_len;
    id_t        mem_ar_id;
    logic       mem_aw_valid, mem_aw_ready;
    addr_t      mem_aw_addr;
    len_t       mem_aw_len;
    id_t        mem_aw_id;
    logic       mem_w_valid, mem_w_ready, mem_w_last;
    bus_t       mem_w_data;
    bus_strb_t  mem_w_strb;
    logic       mem_r_valid, mem_r_last;
    bus_t       mem_r_data;
    resp_t      mem_r_resp;
    id_t        mem_r_id;
    logic       mem_b_valid;
    resp_t      mem_b_resp;
    id_t        mem_b_id;

    l2_serdes serdes0 (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_ar_valid(i_ar_valid), .o_ar_ready(o_ar_ready), .i_ar_addr(i_ar_addr),
        .i_ar_size(i_ar_size), .i_ar_id(i_ar_id),
        .i_aw_valid(i_aw_valid), .o_aw_ready(o_aw_ready), .i_aw_addr(i_aw_addr),
        .i_aw_size(i_aw_size), .i_aw_id(i_aw_id),
        .i_w_data(i_w_data), .i_w_strb(i_w_strb),
        .o_r_valid(o_r_valid), .o_r_data(o_r_data), .o_r_resp(o_r_resp), .o_r_id(o_r_id),
        .o_b_valid(o_b_valid), .o_b_resp(o_b_resp), .o_b_id(o_b_id),
        .o_mem_ar_valid(mem_ar_valid), .i_mem_ar_ready(mem_ar_ready),
        .o_mem_ar_addr(mem_ar_addr), .o_mem_ar_len(mem_ar_len), .o_mem_ar_id(mem_ar_id),
        .o_mem_aw_valid(mem_aw_valid), .i_mem_aw_ready(mem_aw_ready),
        .o_mem_aw_addr(mem_aw_addr), .o_mem_aw_len(mem_aw_len), .o_mem_aw_id(mem_aw_id),
        .o_mem_w_valid(mem_w_valid), .i_mem_w_ready(mem_w_ready),
        .o_mem_w_data(mem_w_data), .o_mem_w_strb(mem_w_strb), .o_mem_w_last(mem_w_last),
        .i_mem_r_valid(mem_r_valid), .i_mem_r_data(mem_r_data), .i_mem_r_resp(mem_r_resp),
        .i_mem_r_id(mem_r_id), .i_mem_r_last(mem_r_last),
        .i_mem_b_valid(mem_b_valid), .i_mem_b_resp(mem_b_resp), .i_mem_b_id(mem_b_id)
    );

    burst_mem mem0 (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_stall(i_mem_stall),
        .i_ar_valid(mem_ar_valid), .o_ar_ready(mem_ar_ready), .i_ar_addr(mem_ar_addr),
        .i_ar_len(mem_ar_len), .i_ar_id(mem_ar_id),
        .i_aw_valid(mem_aw_valid), .o_aw_ready(mem_aw_ready), .i_aw_addr(mem_aw_addr),
        .i_aw_len(mem_aw_len), .i_aw_id(mem_aw_id),
        .i_w_valid(mem_w_valid), .o_w_ready(mem_w_ready), .i_w_data(mem_w_data),
        .i_w_strb(mem_w_strb), .i_w_last(mem_w_last),
        .o_r_valid(mem_r_valid), .o_r_data(mem_r_data), .o_r_resp(mem_r_resp),
        .o_r_id(mem_r_id), .o_r_last(mem_r_last),
        .o_b_valid(mem_b_valid), .o_b_resp(mem_b_resp), .o_b_id(mem_b_id)
    );

endmodule

//--- verilog/l2_serdes.sv
/*
 * Converts whole-line cache requests into 64-bit bus bursts.
 * Reads gather up to four beats into a line, writes shift the line
 * out one beat at a time. One transaction is in flight at a time.
 */

`timescale 1ns/100ps

module l2_serdes (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    // Cache side
    input  logic                        i_ar_valid,
    output logic                        o_ar_ready,
    input  l2_serdes_pkg::addr_t        i_ar_addr,
    input  l2_serdes_pkg::size_t        i_ar_size,
    input  l2_serdes_pkg::id_t          i_ar_id,
    input  logic                        i_aw_valid,
    output logic                        o_aw_ready,
    input  l2_serdes_pkg::addr_t        i_aw_addr,
    input  l2_serdes_pkg::size_t        i_aw_size,
    input  l2_serdes_pkg::id_t          i_aw_id,
    input  l2_serdes_pkg::line_t        i_w_data,
    input  l2_serdes_pkg::line_strb_t   i_w_strb,
    output logic                        o_r_valid,
    output l2_serdes_pkg::line_t        o_r_data,
    output l2_serdes_pkg::resp_t        o_r_resp,
    output l2_serdes_pkg::id_t          o_r_id,
    output logic                        o_b_valid,
    output l2_serdes_pkg::resp_t        o_b_resp,
    output l2_serdes_pkg::id_t          o_b_id,
    // Memory bus side
    output logic                        o_mem_ar_valid,
    input  logic                        i_mem_ar_ready,
    output l2_serdes_pkg::addr_t        o_mem_ar_addr,
    output l2_serdes_pkg::len_t         o_mem_ar_len,
    output l2_serdes_pkg::id_t          o_mem_ar_id,
    output logic                        o_mem_aw_valid,
    input  logic                        i_mem_aw_ready,
    output l2_serdes_pkg::addr_t        o_mem_aw_addr,
    output l2_serdes_pkg::len_t         o_mem_aw_len,
    output l2_serdes_pkg::id_t          o_mem_aw_id,
    output logic                        o_mem_w_valid,
    input  logic                        i_mem_w_ready,
    output l2_serdes_pkg::bus_t         o_mem_w_data,
    output l2_serdes_pkg::bus_strb_t    o_mem_w_strb,
    output logic                        o_mem_w_last,
    input  logic                        i_mem_r_valid,
    input  l2_serdes_pkg::bus_t         i_mem_r_data,
    input  l2_serdes_pkg::resp_t        i_mem_r_resp,
    input  l2_serdes_pkg::id_t          i_mem_r_id,
    input  logic                        i_mem_r_last,
    input  logic                        i_mem_b_valid,
    input  l2_serdes_pkg::resp_t        i_mem_b_resp,
    input  l2_serdes_pkg::id_t          i_mem_b_id
);
    import l2_serdes_pkg::*;

    serdes_state_t      state;
    len_t               req_len;        // Write beats left minus one
    logic [BEATS-1:0]   rmux;           // One-hot lane of the next read beat
    line_t              line_q;
    line_strb_t         wstrb_q;
    resp_t              rresp_q;        // Worst read response so far
    logic               b_wait;         // All beats sent, waiting for B
    line_t              rline;
    resp_t              rresp_cur;
    logic               ar_take;
    logic               aw_take;
    logic               w_take;

    // Burst length from the request size
    function automatic len_t size2len(input size_t size);
        len_t len;
        case (size)
            3'd0, 3'd1, 3'd2, 3'd3: len = 8'd0;
            3'd4:                   len = 8'd1;
            default:                len = 8'd3;
        endcase
        return len;
    endfunction

    // Current read beat dropped into its lane
    always_comb begin
        rline = line_q;
        for (int i = 0; i < BEATS; i++) begin
            if (rmux[i]) begin
                rline[i*BUS_W +: BUS_W] = i_mem_r_data;
            end
        end
    end

    assign rresp_cur = (i_mem_r_resp > rresp_q) ? i_mem_r_resp : rresp_q;

    // Requests pass straight through while idle, reads take priority
    assign o_mem_ar_valid = (state == ST_IDLE) & i_ar_valid;
    assign o_mem_ar_addr  = i_ar_addr;
    assign o_mem_ar_len   = size2len(i_ar_size);
    assign o_mem_ar_id    = i_ar_id;
    assign o_ar_ready     = (state == ST_IDLE) & i_mem_ar_ready;

    assign o_mem_aw_valid = (state == ST_IDLE) & i_aw_valid & ~i_ar_valid;
    assign o_mem_aw_addr  = i_aw_addr;
    assign o_mem_aw_len   = size2len(i_aw_size);
    assign o_mem_aw_id    = i_aw_id;
    assign o_aw_ready     = (state == ST_IDLE) & i_mem_aw_ready & ~i_ar_valid;

    assign ar_take = o_mem_ar_valid & i_mem_ar_ready;
    assign aw_take = o_mem_aw_valid & i_mem_aw_ready;

    // Low beat of the shifting line is always the one on the bus
    assign o_mem_w_valid = (state == ST_WRITE) & ~b_wait;
    assign o_mem_w_last  = o_mem_w_valid & (req_len == '0);
    assign o_mem_w_data  = line_q[BUS_W-1:0];
    assign o_mem_w_strb  = wstrb_q[BUS_B-1:0];
    assign w_take        = o_mem_w_valid & i_mem_w_ready;

    assign o_r_valid = (state == ST_READ) & i_mem_r_valid & i_mem_r_last;
    assign o_r_data  = rline;
    assign o_r_resp  = rresp_cur;
    assign o_r_id    = i_mem_r_id;

    assign o_b_valid = (state == ST_WRITE) & b_wait & i_mem_b_valid;
    assign o_b_resp  = i_mem_b_resp;
    assign o_b_id    = i_mem_b_id;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= ST_IDLE;
            req_len <= '0;
            rmux    <= '0;
            rresp_q <= RESP_OKAY;
            b_wait  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ar_take) begin
                        state   <= ST_READ;
                        rmux    <= {{(BEATS-1){1'b0}}, 1'b1};
                        rresp_q <= RESP_OKAY;
                    end else if (aw_take) begin
                        state   <= ST_WRITE;
                        req_len <= o_mem_aw_len;
                        b_wait  <= 1'b0;
                    end
                end
                ST_READ: begin
                    if (i_mem_r_valid) begin
                        rmux    <= rmux << 1;
                        rresp_q <= rresp_cur;
                        if (i_mem_r_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_WRITE: begin
                    if (w_take) begin
                        if (o_mem_w_last) begin
                            b_wait <= 1'b1;
                        end else begin
                            req_len <= req_len - 8'd1;
                        end
                    end else if (o_b_valid) begin
                        b_wait <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Line buffer, shared by both directions
    always_ff @(posedge i_clk) begin
        if (ar_take) begin
            line_q <= '0;                       // Unfilled lanes read as zero
        end else if (aw_take) begin
            line_q  <= i_w_data;
            wstrb_q <= i_w_strb;
        end else if ((state == ST_READ) && i_mem_r_valid) begin
            line_q <= rline;
        end else if (w_take) begin
            line_q  <= line_q >> BUS_W;
            wstrb_q <= wstrb_q >> BUS_B;
        end
    end

endmodule

//--- verilog/l2_serdes_pkg.sv
/*
 * Shared widths, sizes and types for the line-to-beat converter,
 * the burst memory model and their testbench.
 * Modules pull these in with a wildcard import in the body.
 */

package l2_serdes_pkg;

    localparam int LINE_W    = 256;     // Bits in a cache line
    localparam int BUS_W     = 64;      // Bits in a bus beat
    localparam int LINE_B    = LINE_W / 8;
    localparam int BUS_B     = BUS_W / 8;
    localparam int BEATS     = LINE_W / BUS_W;
    localparam int ADDR_W    = 12;      // Byte address, upper half is out of range
    localparam int ID_W      = 4;
    localparam int MEM_WORDS = 256;     // 2 KB of 64-bit words
    localparam int MEM_LAT   = 2;       // Address accept to first read beat

    // AXI-style response codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [LINE_B-1:0] line_strb_t;
    typedef logic [BUS_W-1:0]  bus_t;
    typedef logic [BUS_B-1:0]  bus_strb_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [2:0]        size_t;  // log2 of bytes per transfer
    typedef logic [7:0]        len_t;   // Beats minus one
    typedef logic [1:0]        resp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } serdes_state_t;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_RLAT,
        MS_READ,
        MS_WRITE,
        MS_RESP
    } mem_state_t;

endpackage
